//--- hw/msg_hub_settings.svh
`ifndef MSG_HUB_SETTINGS_SVH
`define MSG_HUB_SETTINGS_SVH

// number of cores feeding the hub
// the core count must be a power of two
`define MSG_HUB_CORE_COUNT 4

// log2 of the per-core FIFO depth
`define MSG_HUB_FIFO_AWIDTH 2

// width of the AXI4-Lite byte address
`define MSG_HUB_AXIL_AWIDTH 4

`endif

//--- hw/msg_hub_pkg.sv
`include "msg_hub_settings.svh"

package msg_hub_pkg;

  typedef logic [63:0] msg_data_t;
  typedef logic [$clog2(`MSG_HUB_CORE_COUNT)-1:0] core_no_t;

  typedef logic [`MSG_HUB_AXIL_AWIDTH-1:0] axil_addr_t;
  typedef logic [31:0] axil_data_t;
  typedef logic [1:0] axil_resp_t;

  localparam axil_resp_t resp_okay   = 2'd0;
  localparam axil_resp_t resp_slverr = 2'd2;

  // byte offsets of the read-only registers
  localparam axil_addr_t reg_status  = 'h0;
  localparam axil_addr_t reg_data_lo = 'h4;
  localparam axil_addr_t reg_data_hi = 'h8;

  typedef enum logic {
    rd_idle,
    rd_resp
  } axil_rd_state_e;

endpackage

//--- hw/msg_stream_if.sv
interface msg_stream_if;

  msg_hub_pkg::msg_data_t data;
  msg_hub_pkg::core_no_t  core_no;
  logic                   valid;
  logic                   ready;

  // data and core_no stay put while valid is high
  modport source (
    output data, core_no, valid,
    input  ready
  );

  modport sink (
    input  data, core_no, valid,
    output ready
  );

endinterface

//--- hw/msg_fifo.sv
`include "msg_hub_settings.svh"

module msg_fifo (
  input  logic                   clk,
  input  logic                   rst,
  input  msg_hub_pkg::msg_data_t din,
  input  logic                   din_valid,
  output logic                   din_ready,
  output msg_hub_pkg::msg_data_t dout,
  output logic                   dout_valid,
  input  logic                   dout_ready
);

  localparam int AW    = `MSG_HUB_FIFO_AWIDTH;
  localparam int DEPTH = 1 << AW;

  msg_hub_pkg::msg_data_t mem [DEPTH];
  logic [AW-1:0]          wr_ptr;
  logic [AW-1:0]          rd_ptr;
  logic [AW:0]            count;
  logic                   push;
  logic                   pop;

  // a full FIFO refuses pushes even when a pop happens in the same cycle
  assign din_ready  = (count != (AW+1)'(DEPTH));
  assign dout_valid = (count != '0);
  assign push       = din_valid && din_ready;
  assign pop        = dout_valid && dout_ready;
  assign dout       = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  count_within_depth: assert property (
    @(posedge clk) disable iff (rst) count <= (AW+1)'(DEPTH)
  ) else $error("msg_fifo occupancy %0d above depth %0d", count, DEPTH);

endmodule

//--- hw/core_msg_arbiter.sv
`include "msg_hub_settings.svh"

module core_msg_arbiter (
  input  logic                                             clk,
  input  logic                                             rst,
  input  msg_hub_pkg::msg_data_t [`MSG_HUB_CORE_COUNT-1:0] fifo_data,
  input  logic [`MSG_HUB_CORE_COUNT-1:0]                   fifo_valid,
  output logic [`MSG_HUB_CORE_COUNT-1:0]                   fifo_pop,
  msg_stream_if.source                                     out
);

  localparam int N = `MSG_HUB_CORE_COUNT;

  logic                   transfer;
  logic                   transfer_r;
  logic                   transfer_rr;
  msg_hub_pkg::core_no_t  turn;
  logic [2*N-1:0]         valid_shifted;
  logic [N-1:0]           rotated_valid;
  logic                   found_one;
  logic                   found_one_r;
  msg_hub_pkg::core_no_t  core_sel_penc;
  msg_hub_pkg::core_no_t  core_sel;
  msg_hub_pkg::msg_data_t data_reg;
  logic                   valid_reg;

  assign transfer = valid_reg && out.ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      transfer_r  <= 1'b0;
      transfer_rr <= 1'b0;
    end else begin
      transfer_r  <= transfer;
      transfer_rr <= transfer_r;
    end
  end

  // the turn moves on by one per accepted message, not to the winner plus one
  always_ff @(posedge clk) begin
    if (rst) begin
      turn <= '0;
    end else if (transfer) begin
      turn <= turn + 1'b1;
    end
  end

  // doubling the vector turns the right shift into a rotation
  assign valid_shifted = {fifo_valid, fifo_valid} >> turn;
  assign found_one     = |rotated_valid;

  // the snapshot is frozen once a core is found, until the popped FIFO has settled
  always_ff @(posedge clk) begin
    if (rst) begin
      rotated_valid <= '0;
    end else if (!found_one || transfer_r) begin
      rotated_valid <= valid_shifted[N-1:0];
    end
  end

  // lowest set bit is the first waiting core at or after the turn
  always_comb begin
    core_sel_penc = '0;
    for (int i = N - 1; i >= 0; i--) begin
      if (rotated_valid[i]) begin
        core_sel_penc = msg_hub_pkg::core_no_t'(i);
      end
    end
  end

  // the sum wraps modulo the core count, which undoes the rotation
  always_ff @(posedge clk) begin
    core_sel <= core_sel_penc + turn;
    data_reg <= fifo_data[core_sel];
  end

  // after a transfer the turn, the snapshot and the selection each take a cycle
  // so valid stays low for three cycles before the data register is right again
  always_ff @(posedge clk) begin
    if (rst) begin
      found_one_r <= 1'b0;
      valid_reg   <= 1'b0;
    end else begin
      found_one_r <= found_one;
      if (transfer || transfer_r || transfer_rr) begin
        valid_reg <= 1'b0;
      end else begin
        valid_reg <= found_one_r;
      end
    end
  end

  always_comb begin
    fifo_pop = '0;
    if (transfer) begin
      fifo_pop[core_sel] = 1'b1;
    end
  end

  assign out.valid   = valid_reg;
  assign out.data    = data_reg;
  assign out.core_no = core_sel;

  pop_one_hot: assert property (
    @(posedge clk) disable iff (rst) $onehot0(fifo_pop)
  ) else $error("arbiter pops more than one FIFO: %b", fifo_pop);

  pop_only_valid: assert property (
    @(posedge clk) disable iff (rst) (fifo_pop & ~fifo_valid) == '0
  ) else $error("arbiter pops an empty FIFO: pop %b valid %b", fifo_pop, fifo_valid);

endmodule

//--- hw/msg_axil_port.sv
module msg_axil_port (
  input  logic                    clk,
  input  logic                    rst,
  input  msg_hub_pkg::axil_addr_t awaddr,
  input  logic                    awvalid,
  output logic                    awready,
  input  msg_hub_pkg::axil_data_t wdata,
  input  logic [3:0]              wstrb,
  input  logic                    wvalid,
  output logic                    wready,
  output msg_hub_pkg::axil_resp_t bresp,
  output logic                    bvalid,
  input  logic                    bready,
  input  msg_hub_pkg::axil_addr_t araddr,
  input  logic                    arvalid,
  output logic                    arready,
  output msg_hub_pkg::axil_data_t rdata,
  output msg_hub_pkg::axil_resp_t rresp,
  output logic                    rvalid,
  input  logic                    rready,
  msg_stream_if.sink              msg
);

  msg_hub_pkg::axil_rd_state_e rd_state;
  msg_hub_pkg::axil_data_t     rd_word;
  msg_hub_pkg::axil_resp_t     rd_code;
  logic                        ar_hs;
  logic                        aw_hs;
  logic                        w_hs;
  logic                        aw_done;
  logic                        w_done;
  logic                        pop_r;

  assign ar_hs = arvalid && arready;
  assign aw_hs = awvalid && awready;
  assign w_hs  = wvalid && wready;

  // the register map is read-only, so the write address, data and strobes
  // only complete their handshakes and every write is refused
  assign bresp = msg_hub_pkg::resp_slverr;

  always_ff @(posedge clk) begin
    if (rst) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      awready <= awvalid && !awready && !aw_done && !bvalid;
      wready  <= wvalid && !wready && !w_done && !bvalid;
      if (bvalid && bready) begin
        aw_done <= 1'b0;
        w_done  <= 1'b0;
        bvalid  <= 1'b0;
      end else begin
        if (aw_hs) begin
          aw_done <= 1'b1;
        end
        if (w_hs) begin
          w_done <= 1'b1;
        end
        // address and data may finish in either order
        if (!bvalid && (aw_done || aw_hs) && (w_done || w_hs)) begin
          bvalid <= 1'b1;
        end
      end
    end
  end

  always_comb begin
    rd_word = '0;
    rd_code = msg_hub_pkg::resp_okay;
    case (araddr)
      msg_hub_pkg::reg_status: begin
        rd_word[0] = msg.valid;
        rd_word[8 +: $bits(msg_hub_pkg::core_no_t)] = msg.core_no;
      end
      msg_hub_pkg::reg_data_lo: rd_word = msg.data[31:0];
      msg_hub_pkg::reg_data_hi: rd_word = msg.data[63:32];
      default: rd_code = msg_hub_pkg::resp_slverr;
    endcase
  end

  assign rvalid    = (rd_state == msg_hub_pkg::rd_resp);
  assign msg.ready = pop_r;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_state <= msg_hub_pkg::rd_idle;
      arready  <= 1'b0;
      pop_r    <= 1'b0;
    end else begin
      arready <= (rd_state == msg_hub_pkg::rd_idle) && arvalid && !arready;
      // reading the high half pops the presented message one cycle later
      pop_r   <= ar_hs && (araddr == msg_hub_pkg::reg_data_hi) && msg.valid;
      case (rd_state)
        msg_hub_pkg::rd_idle: begin
          if (ar_hs) begin
            rd_state <= msg_hub_pkg::rd_resp;
          end
        end
        msg_hub_pkg::rd_resp: begin
          if (rready) begin
            rd_state <= msg_hub_pkg::rd_idle;
          end
        end
        default: rd_state <= msg_hub_pkg::rd_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      rdata <= rd_word;
      rresp <= rd_code;
    end
  end

  rvalid_held: assert property (
    @(posedge clk) disable iff (rst) rvalid && !rready |=> rvalid
  ) else $error("rvalid dropped before rready");

  bvalid_held: assert property (
    @(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid
  ) else $error("bvalid dropped before bready");

endmodule

//--- hw/msg_hub_top.sv
`include "msg_hub_settings.svh"

module msg_hub_top (
  input  logic                                             clk,
  input  logic                                             rst,
  input  msg_hub_pkg::msg_data_t [`MSG_HUB_CORE_COUNT-1:0] core_msg_data,
  input  logic [`MSG_HUB_CORE_COUNT-1:0]                   core_msg_valid,
  output logic [`MSG_HUB_CORE_COUNT-1:0]                   core_msg_ready,
  input  msg_hub_pkg::axil_addr_t                          awaddr,
  input  logic                                             awvalid,
  output logic                                             awready,
  input  msg_hub_pkg::axil_data_t                          wdata,
  input  logic [3:0]                                       wstrb,
  input  logic                                             wvalid,
  output logic                                             wready,
  output msg_hub_pkg::axil_resp_t                          bresp,
  output logic                                             bvalid,
  input  logic                                             bready,
  input  msg_hub_pkg::axil_addr_t                          araddr,
  input  logic                                             arvalid,
  output logic                                             arready,
  output msg_hub_pkg::axil_data_t                          rdata,
  output msg_hub_pkg::axil_resp_t                          rresp,
  output logic                                             rvalid,
  input  logic                                             rready
);

  msg_hub_pkg::msg_data_t [`MSG_HUB_CORE_COUNT-1:0] fifo_data;
  logic [`MSG_HUB_CORE_COUNT-1:0]                   fifo_valid;
  logic [`MSG_HUB_CORE_COUNT-1:0]                   fifo_pop;

  msg_stream_if msg_bus ();

  // one FIFO per core buffers pushes until the arbiter picks them
  for (genvar j = 0; j < `MSG_HUB_CORE_COUNT; j++) begin : g_core_fifo
    msg_fifo u_fifo (
      .clk        (clk),
      .rst        (rst),
      .din        (core_msg_data[j]),
      .din_valid  (core_msg_valid[j]),
      .din_ready  (core_msg_ready[j]),
      .dout       (fifo_data[j]),
      .dout_valid (fifo_valid[j]),
      .dout_ready (fifo_pop[j])
    );
  end

  core_msg_arbiter u_arbiter (
    .clk        (clk),
    .rst        (rst),
    .fifo_data  (fifo_data),
    .fifo_valid (fifo_valid),
    .fifo_pop   (fifo_pop),
    .out        (msg_bus.source)
  );

  msg_axil_port u_axil_port (
    .clk     (clk),
    .rst     (rst),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .msg     (msg_bus.sink)
  );

endmodule

//--- bench/tb_clk_gen.sv
module tb_clk_gen (
  output logic clk,
  output logic rst
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYCLES = 16;

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // reset drops on a rising edge like every other input
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

//--- bench/msg_hub_tb.sv
`include "msg_hub_settings.svh"

module msg_hub_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N = `MSG_HUB_CORE_COUNT;
  // cycles per handshake wait, status reads per poll, cycles a read is held
  localparam int TIMEOUT = 100;
  localparam int POLL_TRIES = 40;
  localparam int STALL_CYCLES = 6;

  logic clk;
  logic rst;
  msg_hub_pkg::msg_data_t [N-1:0] core_msg_data;
  logic [N-1:0] core_msg_valid;
  logic [N-1:0] core_msg_ready;
  msg_hub_pkg::axil_addr_t awaddr;
  msg_hub_pkg::axil_addr_t araddr;
  msg_hub_pkg::axil_data_t wdata;
  msg_hub_pkg::axil_data_t rdata;
  msg_hub_pkg::axil_resp_t bresp;
  msg_hub_pkg::axil_resp_t rresp;
  logic [3:0] wstrb;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;

  int errors = 0;
  int checks = 0;
  int tests = 0;
  int failed_tests = 0;
  int test_start_errors = 0;
  string test_name = "";
  bit timed_out = 1'b0;

  tb_clk_gen clk_gen (.clk(clk), .rst(rst));

  msg_hub_top UUT (.*);

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    assert (actual === expected)
      else begin
        errors++;
        $display("[FAIL] %s: expected %h, got %h", name, expected, actual);
      end
  endtask

  task automatic note_timeout(input string what);
    timed_out = 1'b1;
    errors++;
    $display("timeout: the DUT never raised %s", what);
  endtask

  task automatic close_test();
    if (test_name != "") begin
      tests++;
      if (errors == test_start_errors) begin
        $display("test %s passed", test_name);
      end else begin
        failed_tests++;
        $display("test %s failed with %0d errors", test_name, errors - test_start_errors);
      end
    end
    test_start_errors = errors;
  endtask

  // ready is sampled one edge before the push so a full FIFO shows up here
  task automatic push_msg(input int core, input msg_hub_pkg::msg_data_t data,
                          input int exp_ready);
    @(posedge clk);
    check_value($sformatf("core_msg_ready[%0d]", core), exp_ready, core_msg_ready[core]);
    core_msg_data[core] <= data;
    core_msg_valid[core] <= 1'b1;
    @(posedge clk);
    core_msg_valid[core] <= 1'b0;
  endtask

  task automatic axil_read(input msg_hub_pkg::axil_addr_t addr, input int stall,
                           output msg_hub_pkg::axil_data_t data,
                           output msg_hub_pkg::axil_resp_t resp);
    bit seen;
    @(posedge clk);
    araddr <= addr;
    arvalid <= 1'b1;
    seen = 1'b0;
    for (int n = 0; n < TIMEOUT && !seen; n++) begin
      @(posedge clk);
      seen = arready;
    end
    arvalid <= 1'b0;
    if (!seen) begin
      note_timeout("arready");
      return;
    end
    seen = 1'b0;
    for (int n = 0; n < TIMEOUT && !seen; n++) begin
      @(posedge clk);
      seen = rvalid;
    end
    if (!seen) begin
      note_timeout("rvalid");
      return;
    end
    data = rdata;
    resp = rresp;
    // with rready low the response must not move
    repeat (stall) begin
      @(posedge clk);
      check_value("rvalid", 1'b1, rvalid);
      check_value("rdata", data, rdata);
    end
    rready <= 1'b1;
    @(posedge clk);
    rready <= 1'b0;
  endtask

  task automatic run_read(input msg_hub_pkg::axil_addr_t addr, input logic [63:0] expected,
                          input int exp_resp, input string flag);
    msg_hub_pkg::axil_data_t data;
    msg_hub_pkg::axil_resp_t resp;
    int tries;
    tries = 0;
    axil_read(addr, (flag == "stall") ? STALL_CYCLES : 0, data, resp);
    while (flag == "wait" && !timed_out && data[0] !== 1'b1 && tries < POLL_TRIES) begin
      tries++;
      axil_read(addr, 0, data, resp);
    end
    if (flag == "wait" && !timed_out && data[0] !== 1'b1) begin
      note_timeout("the status valid bit");
    end
    if (!timed_out) begin
      // with no message presented only the valid bit of the status word is defined
      if (addr == msg_hub_pkg::reg_status && expected[0] == 1'b0) begin
        check_value($sformatf("rdata[0] at %h", addr), expected[0], data[0]);
      end else begin
        check_value($sformatf("rdata at %h", addr), expected, data);
      end
      check_value($sformatf("rresp at %h", addr), exp_resp, resp);
    end
  endtask

  task automatic run_write(input msg_hub_pkg::axil_addr_t addr,
                           input msg_hub_pkg::axil_data_t data, input int exp_resp);
    bit aw_seen;
    bit w_seen;
    bit b_seen;
    @(posedge clk);
    awaddr <= addr;
    awvalid <= 1'b1;
    wdata <= data;
    wstrb <= 4'hf;
    wvalid <= 1'b1;
    bready <= 1'b1;
    aw_seen = 1'b0;
    w_seen = 1'b0;
    for (int n = 0; n < TIMEOUT && !(aw_seen && w_seen); n++) begin
      @(posedge clk);
      if (!aw_seen && awready) begin
        aw_seen = 1'b1;
        awvalid <= 1'b0;
      end
      if (!w_seen && wready) begin
        w_seen = 1'b1;
        wvalid <= 1'b0;
      end
    end
    b_seen = 1'b0;
    for (int n = 0; n < TIMEOUT && aw_seen && w_seen && !b_seen; n++) begin
      @(posedge clk);
      b_seen = bvalid;
    end
    bready <= 1'b0;
    if (!(aw_seen && w_seen && b_seen)) begin
      note_timeout("awready, wready or bvalid");
    end else begin
      check_value($sformatf("bresp at %h", addr), exp_resp, bresp);
    end
  endtask

  initial begin
    int fd;
    string line;
    string cmd;
    string flag;
    int core;
    int exp_ready;
    int exp_resp;
    logic [63:0] value;
    logic [63:0] expected;
    msg_hub_pkg::axil_addr_t addr;
    bit seen;
    core_msg_data = '0;
    core_msg_valid = '0;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    seen = 1'b0;
    for (int n = 0; n < TIMEOUT && !seen; n++) begin
      @(posedge clk);
      seen = !rst;
    end
    if (!seen) begin
      note_timeout("the end of reset");
    end
    fd = $fopen("bench/msg_hub_testdata.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("cannot open bench/msg_hub_testdata.txt");
    end
    while (fd != 0 && !timed_out && $fgets(line, fd) > 0) begin
      if ($sscanf(line, "%s", cmd) < 1 || cmd.substr(0, 0) == "#") begin
        continue;
      end
      if (cmd == "test") begin
        close_test();
        void'($sscanf(line, "%s %s", cmd, test_name));
      end else if (cmd == "push") begin
        void'($sscanf(line, "%s %d %h %d", cmd, core, value, exp_ready));
        push_msg(core, value, exp_ready);
      end else if (cmd == "read") begin
        void'($sscanf(line, "%s %h %h %h %s", cmd, addr, expected, exp_resp, flag));
        run_read(addr, expected, exp_resp, flag);
      end else if (cmd == "write") begin
        void'($sscanf(line, "%s %h %h %h", cmd, addr, value, exp_resp));
        run_write(addr, value[31:0], exp_resp);
      end else begin
        errors++;
        $display("unknown command %s in the test data", cmd);
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    close_test();
    $display("%0d tests, %0d failed, %0d checks, %0d errors", tests, failed_tests, checks,
             errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+hw
hw/msg_hub_pkg.sv
hw/msg_stream_if.sv
hw/msg_fifo.sv
hw/core_msg_arbiter.sv
hw/msg_axil_port.sv
hw/msg_hub_top.sv
bench/tb_clk_gen.sv
bench/msg_hub_tb.sv

//--- Bender.yml
package:
  name: msg_hub

sources:
  - include_dirs:
      - hw
    files:
      - hw/msg_hub_pkg.sv
      - hw/msg_stream_if.sv
      - hw/msg_fifo.sv
      - hw/core_msg_arbiter.sv
      - hw/msg_axil_port.sv
      - hw/msg_hub_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/tb_clk_gen.sv
      - bench/msg_hub_tb.sv

//--- bench/msg_hub_testdata.txt
# push <core> <data hex> <core_msg_ready before the push>, write <addr> <wdata> <bresp>
# read <addr> <rdata> <rresp> <mode>, mode is - plain, wait polls bit 0, stall holds rready
test round_robin
push 0 a0a0a0a000000000 1
push 1 a1a1a1a111111111 1
push 2 a2a2a2a222222222 1
push 3 a3a3a3a333333333 1
read 0 00000001 0 wait
read 8 a0a0a0a0 0 -
read 0 00000101 0 wait
read 8 a1a1a1a1 0 -
read 0 00000201 0 wait
read 8 a2a2a2a2 0 -
read 0 00000301 0 wait
read 8 a3a3a3a3 0 -
test single_message
push 2 0123456789abcdef 1
read 0 00000201 0 wait
read 4 89abcdef 0 -
read 8 01234567 0 -
read 0 00000000 0 -
test fifo_order
push 1 0000001a000000a1 1
push 1 0000001b000000b1 1
push 1 0000001c000000c1 1
push 3 0000003d000000d3 1
read 0 00000101 0 wait
read 8 0000001a 0 -
read 0 00000301 0 wait
read 8 0000003d 0 -
read 0 00000101 0 wait
read 8 0000001b 0 -
read 0 00000101 0 wait
read 8 0000001c 0 -
test full_fifo
push 0 000000f100000001 1
push 0 000000f200000002 1
push 0 000000f300000003 1
push 0 000000f400000004 1
push 0 000000f500000005 0
read 0 00000001 0 wait
read 8 000000f1 0 -
read 0 00000001 0 wait
read 8 000000f2 0 -
read 0 00000001 0 wait
read 8 000000f3 0 -
read 0 00000001 0 wait
read 4 00000004 0 -
read 8 000000f4 0 -
read 0 00000000 0 -
test errors_and_backpressure
read c 00000000 2 -
write 0 deadbeef 2
write 8 0badcafe 2
push 3 c0ffee0012345678 1
read 0 00000301 0 wait
read 4 12345678 0 stall
read 8 c0ffee00 0 -
read 0 00000000 0 -
